//--- Makefile
# Verilator build and run for the branch predictor

TOP := tb_branch_predictor

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f flist.f --Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee run.log
	grep -q "Done: no errors" run.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir run.log

//--- dv/branch_patterns.txt
# op pc taken target predicted write_bht write_btb enable exp_taken exp_counter exp_target
# All fields hex; U lines ignore the expected columns, L lines use only pc and enable
L 0104 0 0000 0 0 0 1 0 0 0000
L 0a06 0 0000 0 0 0 1 0 0 0000
U 0104 1 0200 0 1 1 1 0 0 0000
L 0104 0 0000 0 0 0 1 0 1 0200
U 0104 1 0200 1 1 1 1 0 0 0000
L 0104 0 0000 0 0 0 1 1 2 0200
U 0104 1 0200 2 1 1 1 0 0 0000
L 0104 0 0000 0 0 0 1 1 3 0200
U 0104 1 0200 3 1 1 1 0 0 0000
L 0104 0 0000 0 0 0 1 1 3 0200
L 0204 0 0000 0 0 0 1 0 3 0000
U 0104 0 0200 3 1 1 1 0 0 0000
L 0104 0 0000 0 0 0 1 1 2 0200
U 0104 0 0200 2 1 1 1 0 0 0000
L 0104 0 0000 0 0 0 1 0 1 0200
U 0104 0 0200 1 1 1 1 0 0 0000
L 0104 0 0000 0 0 0 1 0 0 0200
U 0104 0 0200 0 1 1 1 0 0 0000
L 0104 0 0000 0 0 0 1 0 0 0200
U 0104 1 0300 0 1 0 1 0 0 0000
L 0104 0 0000 0 0 0 1 0 1 0200
U 0104 1 0300 1 0 1 1 0 0 0000
L 0104 0 0000 0 0 0 1 0 1 0300
L 0104 0 0000 0 0 0 0 0 0 0000
U 0104 1 0400 1 1 1 0 0 0 0000
L 0104 0 0000 0 0 0 1 0 1 0300
U 0a06 1 0123 2 1 1 1 0 0 0000
L 0a06 0 0000 0 0 0 1 1 3 0123
L 0104 0 0000 0 0 0 1 0 1 0300

//--- dv/tb_branch_predictor.sv
/*
 * Testbench for the branch predictor top level
 * Pattern file driven req/ack updates and lookup checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;

  import bp_addr_pkg::*;
  import bp_update_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int ACK_TIMEOUT = 20;              // Cycles allowed per handshake wait

  logic    clk;
  logic    rst;
  logic    enable;
  pc_t     lookup_pc;
  update_t update;
  logic    update_req;
  lookup_t lookup;
  logic    update_ack;

  int error_count;
  int step_count;
  int update_count;
  int lookup_count;
  bit step_ok;                                  // Cleared by any failure in the step
  bit timed_out;                                // Stops the pattern loop

  // Fields of the current pattern line
  byte      op;
  pc_t      pat_pc;
  logic     pat_taken;
  target_t  pat_target;
  counter_t pat_predicted;
  logic     pat_write_bht;
  logic     pat_write_btb;
  logic     pat_enable;
  logic     exp_taken;
  counter_t exp_counter;
  target_t  exp_target;

  branch_predictor_top #(.INDEX_BITS(3)) i_branch_predictor_top (
    .clk(clk), .rst(rst), .enable(enable), .lookup_pc(lookup_pc),
    .update(update), .update_req(update_req),
    .lookup(lookup), .update_ack(update_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      $display("FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
      error_count++;
      step_ok = 1'b0;
    end
  endtask

  // Polls update_ack one edge at a time
  task automatic wait_ack(input logic level, output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < ACK_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
      if (update_ack === level) seen = 1'b1;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: update_ack did not %s within %0d cycles", $time, what,
             ACK_TIMEOUT);
    error_count++;
    step_ok   = 1'b0;
    timed_out = 1'b1;
  endtask

  // One full four-phase transaction
  task automatic run_update();
    bit seen;
    update_count++;
    if (update_ack !== 1'b0) begin
      $display("Handshake error at %0t: update_ack high before the request", $time);
      error_count++;
      step_ok = 1'b0;
    end
    enable           = pat_enable;
    update.pc        = pat_pc;
    update.predicted = pat_predicted;
    update.taken     = pat_taken;
    update.target    = pat_target;
    update.write_bht = pat_write_bht;
    update.write_btb = pat_write_btb;
    update_req       = 1'b1;
    wait_ack(1'b1, seen);
    if (!seen) begin
      report_timeout("rise");
      return;
    end
    @(posedge clk);                             // Hold req one more cycle
    #1;
    if (update_ack !== 1'b1) begin
      $display("Handshake error at %0t: update_ack fell while update_req was high", $time);
      error_count++;
      step_ok = 1'b0;
    end
    update_req = 1'b0;
    wait_ack(1'b0, seen);
    if (!seen) report_timeout("fall");
  endtask

  task automatic run_lookup();
    lookup_count++;
    enable    = pat_enable;
    lookup_pc = pat_pc;
    @(posedge clk);
    @(negedge clk);                             // Sample mid cycle
    check_value("lookup.taken", 16'(exp_taken), 16'(lookup.taken));
    check_value("lookup.counter", 16'(exp_counter), 16'(lookup.counter));
    check_value("lookup.target", exp_target, lookup.target);
  endtask

  ////////////////////////////////////////////////////////////
  // Pattern loop
  ////////////////////////////////////////////////////////////
  initial begin
    string line;
    int    fd;
    int    code;
    int    n;
    error_count  = 0;
    step_count   = 0;
    update_count = 0;
    lookup_count = 0;
    timed_out    = 1'b0;
    rst          = 1'b1;
    enable       = 1'b0;
    lookup_pc    = '0;
    update       = '0;
    update_req   = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;

    fd = $fopen("dv/branch_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file dv/branch_patterns.txt");
      error_count++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h", op, pat_pc, pat_taken,
                      pat_target, pat_predicted, pat_write_bht, pat_write_btb,
                      pat_enable, exp_taken, exp_counter, exp_target);
          @(posedge clk);
          #1;                                   // Drive just after the edge
          step_count++;
          step_ok = 1'b1;
          if (n != 11) begin
            $display("Pattern line %0d is malformed, %0d fields read", step_count, n);
            error_count++;
            step_ok = 1'b0;
          end else if (op == "U") begin
            run_update();
          end else if (op == "L") begin
            run_lookup();
          end else begin
            $display("Pattern line %0d has an unknown operation", step_count);
            error_count++;
            step_ok = 1'b0;
          end
          $display("step %0d %s pc %h: %s", step_count, (op == "U") ? "update" : "lookup",
                   pat_pc, step_ok ? "ok" : "failed");
        end
      end
      $fclose(fd);
    end

    $display("steps %0d, updates %0d, lookups %0d, errors %0d", step_count, update_count,
             lookup_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
hdl/bp_addr_pkg.sv
hdl/bp_update_pkg.sv
hdl/branch_history_table.sv
hdl/branch_target_buffer.sv
hdl/bht_btb_update_ctrl.sv
hdl/branch_predictor_top.sv
dv/tb_branch_predictor.sv

//--- hdl/bht_btb_update_ctrl.sv
/*
 * Update controller for the BHT and BTB
 * Four-phase req/ack slave, saturating counter transition
 * Drives one-cycle write strobes into both tables
 */
`timescale 1ns/1ps
`default_nettype none

module bht_btb_update_ctrl #(
  parameter int INDEX_BITS = 3                  // Table index width
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   enable,      // Global predictor enable
  input  wire bp_update_pkg::update_t update,      // Record from decode
  input  wire logic                   update_req,  // Four-phase request
  output logic                        update_ack,  // Four-phase acknowledge
  output logic                        bht_write,
  output bp_addr_pkg::pc_t            bht_pc,
  output bp_addr_pkg::counter_t       bht_counter,
  output logic                        btb_write,
  output bp_addr_pkg::pc_t            btb_pc,
  output bp_addr_pkg::target_t        btb_target
);

  import bp_addr_pkg::*;
  import bp_update_pkg::*;

  upd_state_t state;
  upd_state_t state_next;
  update_t    upd_q;                            // Record held for the whole transaction
  counter_t   counter_next;

  // Index plus tag must fit above the halfword bit
  if (INDEX_BITS < 1 || INDEX_BITS > PC_WIDTH - 2) begin : g_index_range
    $error("INDEX_BITS out of range");
  end

  ////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_next = state;
    case (state)
      IDLE:    if (update_req) state_next = WRITE;   // Latch and go
      WRITE:   state_next = ACK;                     // Tables written at this edge
      ACK:     if (!update_req) state_next = RELEASE; // Requester holds us here
      RELEASE: state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) state <= IDLE;
    else     state <= state_next;
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && update_req) upd_q <= update; // Only sampled at acceptance
  end

  ////////////////////////////////////////////////////////////
  // Counter transition
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (upd_q.predicted)
      COUNTER_SNT: counter_next = upd_q.taken ? COUNTER_WNT : COUNTER_SNT;
      COUNTER_WNT: counter_next = upd_q.taken ? COUNTER_WT  : COUNTER_SNT;
      COUNTER_WT:  counter_next = upd_q.taken ? COUNTER_ST  : COUNTER_WNT;
      default:     counter_next = upd_q.taken ? COUNTER_ST  : COUNTER_WT;  // Strong taken
    endcase
  end

  // Strobes, suppressed while the predictor is off
  assign bht_write   = (state == WRITE) && upd_q.write_bht && enable;
  assign btb_write   = (state == WRITE) && upd_q.write_btb && enable;
  assign bht_pc      = upd_q.pc;
  assign bht_counter = counter_next;
  assign btb_pc      = upd_q.pc;
  assign btb_target  = upd_q.target;

  assign update_ack  = (state == ACK);          // Acked even when nothing was written

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  a_req_held : assert property (@(posedge clk) disable iff (rst)
    state == WRITE |-> update_req)
    else $error("update_req dropped before update_ack");

endmodule

`default_nettype wire

//--- hdl/bp_addr_pkg.sv
/*
 * Address and prediction types for the branch predictor
 * PC, target and saturating counter types, lookup result struct
 */
`default_nettype none

package bp_addr_pkg;

  localparam int PC_WIDTH = 16;                 // Instruction address width

  typedef logic [PC_WIDTH-1:0] pc_t;            // Halfword aligned instruction address
  typedef logic [PC_WIDTH-1:0] target_t;        // Branch target address
  typedef logic [1:0]          counter_t;       // 2-bit saturating counter

  // Counter states
  localparam counter_t COUNTER_SNT = 2'd0;      // Strong not taken
  localparam counter_t COUNTER_WNT = 2'd1;      // Weak not taken
  localparam counter_t COUNTER_WT  = 2'd2;      // Weak taken
  localparam counter_t COUNTER_ST  = 2'd3;      // Strong taken

  localparam counter_t COUNTER_RESET = COUNTER_SNT;

  // Lookup result seen by fetch, 19 bits
  typedef struct packed {
    logic     taken;                            // Predict taken
    counter_t counter;                          // Raw BHT counter
    target_t  target;                           // Predicted target
  } lookup_t;

endpackage

`default_nettype wire

//--- hdl/bp_update_pkg.sv
/*
 * Update side types for the branch predictor
 * Decode stage update record, update controller states
 */
`default_nettype none

package bp_update_pkg;

  // Resolved branch from decode, 37 bits
  typedef struct packed {
    bp_addr_pkg::pc_t      pc;                  // Branch PC
    bp_addr_pkg::counter_t predicted;           // Counter returned by lookup
    logic                  taken;               // Actual outcome
    bp_addr_pkg::target_t  target;              // Actual target
    logic                  write_bht;           // Request BHT write
    logic                  write_btb;           // Request BTB write
  } update_t;

  // Four-phase slave FSM
  typedef enum logic [1:0] {
    IDLE    = 2'd0,                             // Waiting for req
    WRITE   = 2'd1,                             // Table strobes high
    ACK     = 2'd2,                             // Ack high until req drops
    RELEASE = 2'd3                              // Ack low, one cycle
  } upd_state_t;

endpackage

`default_nettype wire

//--- hdl/branch_history_table.sv
/*
 * Branch history table
 * Direct mapped valid, tag and 2-bit counter per entry
 * Combinational read port, synchronous write port
 */
`timescale 1ns/1ps
`default_nettype none

module branch_history_table #(
  parameter int INDEX_BITS = 3                  // log2 of entry count
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire bp_addr_pkg::pc_t      lookup_pc,     // Fetch stage PC
  input  wire logic                  write,         // Write strobe from controller
  input  wire bp_addr_pkg::pc_t      write_pc,      // Branch PC being written
  input  wire bp_addr_pkg::counter_t write_counter, // Next counter state
  output logic                       hit,           // Valid and tag match
  output bp_addr_pkg::counter_t      counter        // Raw indexed counter
);

  import bp_addr_pkg::*;

  localparam int TAG_BITS = PC_WIDTH - 1 - INDEX_BITS; // Bits above index and halfword bit
  localparam int ENTRIES  = 1 << INDEX_BITS;

  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0]   tag_t;

  logic     valid_mem   [ENTRIES];              // Entry holds a branch
  tag_t     tag_mem     [ENTRIES];              // Upper PC bits of that branch
  counter_t counter_mem [ENTRIES];              // Its saturating counter

  index_t rd_index;
  tag_t   rd_tag;
  index_t wr_index;
  tag_t   wr_tag;

  assign rd_index = lookup_pc[INDEX_BITS:1];    // Skip halfword bit
  assign rd_tag   = lookup_pc[PC_WIDTH-1:INDEX_BITS+1];
  assign wr_index = write_pc[INDEX_BITS:1];
  assign wr_tag   = write_pc[PC_WIDTH-1:INDEX_BITS+1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) begin
        valid_mem[i]   <= 1'b0;
        tag_mem[i]     <= '0;
        counter_mem[i] <= COUNTER_RESET;        // Everything starts strong not taken
      end
    end else if (write) begin
      valid_mem[wr_index]   <= 1'b1;
      tag_mem[wr_index]     <= wr_tag;
      counter_mem[wr_index] <= write_counter;
    end
  end

  // Reads see pre-edge contents, even in a write cycle
  assign hit     = valid_mem[rd_index] && (tag_mem[rd_index] == rd_tag);
  assign counter = counter_mem[rd_index];       // Returned on miss too

  // Controller must hand over a resolved PC with every strobe
  a_write_pc_known : assert property (@(posedge clk) disable iff (rst)
    write |-> !$isunknown(write_pc))
    else $error("BHT write with unknown PC");

endmodule

`default_nettype wire

//--- hdl/branch_predictor_top.sv
/*
 * Branch predictor top level
 * BHT, BTB, update controller and enable gating of lookup
 */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_top #(
  parameter int INDEX_BITS = 3                  // 8 entries by default
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   enable,     // Low forces not taken, blocks writes
  input  wire bp_addr_pkg::pc_t       lookup_pc,  // Fetch stage PC
  input  wire bp_update_pkg::update_t update,     // Resolved branch from decode
  input  wire logic                   update_req,
  output bp_addr_pkg::lookup_t        lookup,     // Gated prediction
  output logic                        update_ack
);

  import bp_addr_pkg::*;

  logic     bht_hit;
  counter_t bht_rd_counter;
  logic     btb_hit;
  target_t  btb_rd_target;

  logic     bht_write;
  pc_t      bht_wr_pc;
  counter_t bht_wr_counter;
  logic     btb_write;
  pc_t      btb_wr_pc;
  target_t  btb_wr_target;

  branch_history_table #(.INDEX_BITS(INDEX_BITS)) i_branch_history_table (
    .clk(clk), .rst(rst), .lookup_pc(lookup_pc),
    .write(bht_write), .write_pc(bht_wr_pc), .write_counter(bht_wr_counter),
    .hit(bht_hit), .counter(bht_rd_counter)
  );

  branch_target_buffer #(.INDEX_BITS(INDEX_BITS)) i_branch_target_buffer (
    .clk(clk), .rst(rst), .lookup_pc(lookup_pc),
    .write(btb_write), .write_pc(btb_wr_pc), .write_target(btb_wr_target),
    .hit(btb_hit), .target(btb_rd_target)
  );

  bht_btb_update_ctrl #(.INDEX_BITS(INDEX_BITS)) i_bht_btb_update_ctrl (
    .clk(clk), .rst(rst), .enable(enable), .update(update), .update_req(update_req),
    .update_ack(update_ack),
    .bht_write(bht_write), .bht_pc(bht_wr_pc), .bht_counter(bht_wr_counter),
    .btb_write(btb_write), .btb_pc(btb_wr_pc), .btb_target(btb_wr_target)
  );

  // Zero latency lookup, all fields cleared when disabled
  always_comb begin
    lookup.taken   = enable && bht_hit && bht_rd_counter[1]; // Upper bit means taken
    lookup.counter = enable ? bht_rd_counter : '0;           // Raw, even on tag miss
    lookup.target  = (enable && btb_hit) ? btb_rd_target : '0;
  end

endmodule

`default_nettype wire

//--- hdl/branch_target_buffer.sv
/*
 * Branch target buffer
 * Direct mapped valid, tag and target address per entry
 */
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer #(
  parameter int INDEX_BITS = 3                  // log2 of entry count
) (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire bp_addr_pkg::pc_t     lookup_pc,  // Fetch stage PC
  input  wire logic                 write,      // Write strobe from controller
  input  wire bp_addr_pkg::pc_t     write_pc,   // Branch PC being written
  input  wire bp_addr_pkg::target_t write_target,
  output logic                      hit,        // Valid and tag match
  output bp_addr_pkg::target_t      target      // Zero on miss
);

  import bp_addr_pkg::*;

  localparam int TAG_BITS = PC_WIDTH - 1 - INDEX_BITS;
  localparam int ENTRIES  = 1 << INDEX_BITS;

  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0]   tag_t;

  logic    valid_mem  [ENTRIES];
  tag_t    tag_mem    [ENTRIES];
  target_t target_mem [ENTRIES];

  index_t rd_index;
  tag_t   rd_tag;
  index_t wr_index;

  assign rd_index = lookup_pc[INDEX_BITS:1];
  assign rd_tag   = lookup_pc[PC_WIDTH-1:INDEX_BITS+1];
  assign wr_index = write_pc[INDEX_BITS:1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) begin
        valid_mem[i]  <= 1'b0;
        tag_mem[i]    <= '0;
        target_mem[i] <= '0;
      end
    end else if (write) begin
      valid_mem[wr_index]  <= 1'b1;
      tag_mem[wr_index]    <= write_pc[PC_WIDTH-1:INDEX_BITS+1];
      target_mem[wr_index] <= write_target;     // Overwrites any older branch here
    end
  end

  assign hit    = valid_mem[rd_index] && (tag_mem[rd_index] == rd_tag);
  assign target = hit ? target_mem[rd_index] : '0;

  // Controller FSM must still be idle on the first edge out of reset
  a_no_write_after_rst : assert property (@(posedge clk) $past(rst) |-> !write)
    else $error("BTB written during or right after reset");

endmodule

`default_nettype wire
